// File: verilog/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// number of parallel mac lanes, one output channel each
`define CONV_LANES 4

// pixel and weight value width
`define CONV_DATA_W 8

// memory word width
`define CONV_WORD_W 32

// memory depths in words
`define CONV_IMG_DEPTH 256
`define CONV_OUT_DEPTH 512
`define CONV_W_DEPTH 32
`define CONV_P_DEPTH 8

// largest kernel is 3x3
`define CONV_MAX_TAPS 9

`endif

// File: verilog/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

  typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
  typedef logic [1:0] wcode_t;
  typedef logic signed [19:0] acc_t;
  typedef logic [15:0] addr_t;

  // 0 params, 1 weights, 2 image, 3 output
  typedef logic [1:0] mem_sel_t;

  typedef enum logic [6:0] {
    S_IDLE       = 7'b0000001,
    S_READ_PARAM = 7'b0000010,
    S_READ_QUANT = 7'b0000100,
    S_READ_W     = 7'b0001000,
    S_CONV       = 7'b0010000,
    S_NEXT_GROUP = 7'b0100000,
    S_FINISH     = 7'b1000000
  } ctrl_state_t;

  typedef struct packed {
    logic        en;
    logic        we;
    mem_sel_t    sel;
    addr_t       addr;
    logic [31:0] wdata;
  } host_req_t;

  typedef struct packed {
    pixel_t     pos_w;
    pixel_t     neg_w1;
    pixel_t     neg_w2;
    logic [4:0] shift;
  } quant_t;

  typedef struct packed {
    logic                         valid;
    logic                         first;
    logic                         last;
    logic                         pad;
    wcode_t [`CONV_LANES-1:0]     code;
  } tap_t;

  // weight load strobe with its tap slot
  typedef struct packed {
    logic       valid;
    logic [3:0] idx;
  } wload_t;

endpackage

// File: verilog/conv_ram.sv
module conv_ram
  import conv_pkg::*;
#(
  parameter int DEPTH = 256,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             en,
  input  logic             we,
  input  addr_t            addr,
  input  logic [WIDTH-1:0] wdata,
  output logic [WIDTH-1:0] rdata
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];

  // upper address bits are ignored
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr[AW-1:0]] <= wdata;
      end else begin
        rdata <= mem[addr[AW-1:0]];
      end
    end
  end

endmodule

// File: verilog/conv_ctrl.sv
`include "conv_params.svh"

module conv_ctrl
  import conv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic [31:0] p_rdata,
  input  logic [31:0] w_rdata,
  output logic        finish,
  output addr_t       p_addr,
  output addr_t       w_addr,
  output addr_t       in_addr,
  output logic        in_re,
  output addr_t       out_addr,
  output logic        out_we,
  output wload_t      load_w,
  output quant_t      quant,
  output tap_t        tap
);

  ctrl_state_t state, state_nx;
  logic [15:0] cnt;

  // row_col, out_ch, k, shift from oldest to newest
  logic [3:0][15:0] par_q;
  logic [15:0] row_col;
  logic [15:0] out_ch;
  logic [15:0] k;
  logic [7:0]  k2;
  logic [15:0] groups;
  logic [15:0] grp;
  logic        last_grp;
  addr_t       w_base;
  addr_t       out_ptr;

  logic signed [16:0] pr, pc, ki, kj;
  logic signed [16:0] rc_s, k_s, pad_s;
  logic signed [16:0] ir, ic, lin;
  logic [3:0]  tix;
  logic        outside;
  logic        last_tap;
  logic        conv_done;

  logic        t_valid, t_first, t_last, t_pad;
  addr_t       t_addr;
  logic [1:0]  we_pipe;
  addr_t       addr_pipe [2];

  assign row_col  = par_q[3];
  assign out_ch   = par_q[2];
  assign k        = par_q[1];
  assign k2       = k[3:0] * k[3:0];
  assign groups   = (out_ch + 16'd3) >> 2;
  assign last_grp = grp == groups - 16'd1;

  assign rc_s  = $signed({1'b0, row_col});
  assign k_s   = $signed({1'b0, k});
  assign pad_s = k_s >>> 1;

  // padded image coordinate of the current tap
  assign ir      = pr + ki - pad_s;
  assign ic      = pc + kj - pad_s;
  assign outside = ir < 0 || ir >= rc_s || ic < 0 || ic >= rc_s;
  assign lin     = ir * rc_s + ic;

  assign last_tap  = tix == k2[3:0] - 4'd1;
  assign conv_done = last_tap && pr == rc_s - 1 && pc == rc_s - 1;

  always_comb begin
    state_nx = state;
    case (state)
      S_IDLE:       if (start) state_nx = S_READ_PARAM;
      S_READ_PARAM: if (cnt == 16'd4) state_nx = S_READ_QUANT;
      S_READ_QUANT: if (cnt == 16'd1) state_nx = S_READ_W;
      S_READ_W:     if (cnt == {8'd0, k2}) state_nx = S_CONV;
      S_CONV:       if (conv_done) state_nx = S_NEXT_GROUP;
      S_NEXT_GROUP: begin
        if (cnt == 16'd2) state_nx = last_grp ? S_FINISH : S_READ_W;
      end
      S_FINISH:     if (start) state_nx = S_READ_PARAM;
      default:      state_nx = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nx;
      cnt   <= (state_nx != state) ? 16'd0 : cnt + 16'd1;
    end
  end

  assign finish  = state == S_FINISH;
  assign p_addr  = (state == S_READ_PARAM) ? cnt : 16'd4;
  assign w_addr  = (state == S_READ_W) ? w_base + cnt : w_base + {12'd0, tix};
  assign in_re   = state == S_CONV && !outside;
  assign in_addr = lin[15:0];

  // parameter shift chain and quant word
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      par_q <= '0;
      quant <= '0;
    end else begin
      if (state == S_READ_PARAM && cnt != 16'd0) begin
        par_q <= {par_q[2:0], p_rdata[15:0]};
      end
      if (state == S_READ_QUANT && cnt == 16'd1) begin
        quant.pos_w  <= p_rdata[31:24];
        quant.neg_w1 <= p_rdata[23:16];
        quant.neg_w2 <= p_rdata[15:8];
        quant.shift  <= par_q[0][4:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      grp    <= '0;
      w_base <= '0;
    end else if (state == S_READ_PARAM) begin
      grp    <= '0;
      w_base <= '0;
    end else if (state == S_NEXT_GROUP && cnt == 16'd2 && !last_grp) begin
      grp    <= grp + 16'd1;
      w_base <= w_base + {8'd0, k2};
    end
  end

  // weight data returns one cycle after the address
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      load_w <= '0;
    end else begin
      load_w.valid <= state == S_READ_W && cnt < {8'd0, k2};
      load_w.idx   <= cnt[3:0];
    end
  end

  // pixel and tap walk, row-major in both
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pr      <= '0;
      pc      <= '0;
      ki      <= '0;
      kj      <= '0;
      tix     <= '0;
      out_ptr <= '0;
    end else if (state == S_READ_W) begin
      pr      <= '0;
      pc      <= '0;
      ki      <= '0;
      kj      <= '0;
      tix     <= '0;
      out_ptr <= grp;
    end else if (state == S_CONV) begin
      if (last_tap) begin
        tix     <= '0;
        ki      <= '0;
        kj      <= '0;
        out_ptr <= out_ptr + groups;
        if (pc == rc_s - 1) begin
          pc <= '0;
          pr <= pr + 17'sd1;
        end else begin
          pc <= pc + 17'sd1;
        end
      end else begin
        tix <= tix + 4'd1;
        if (kj == k_s - 1) begin
          kj <= '0;
          ki <= ki + 17'sd1;
        end else begin
          kj <= kj + 17'sd1;
        end
      end
    end
  end

  // tap stage lines up with image and weight read data
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      t_valid <= 1'b0;
      t_first <= 1'b0;
      t_last  <= 1'b0;
      t_pad   <= 1'b0;
      we_pipe <= '0;
    end else begin
      t_valid <= state == S_CONV;
      t_first <= state == S_CONV && tix == 4'd0;
      t_last  <= state == S_CONV && last_tap;
      t_pad   <= state == S_CONV && outside;
      we_pipe <= {we_pipe[0], t_last};
    end
  end

  always_ff @(posedge clk) begin
    t_addr       <= out_ptr;
    addr_pipe[0] <= t_addr;
    addr_pipe[1] <= addr_pipe[0];
  end

  // mac result settles two cycles after the last tap
  assign out_we   = we_pipe[1];
  assign out_addr = addr_pipe[1];

  always_comb begin
    tap.valid = t_valid;
    tap.first = t_first;
    tap.last  = t_last;
    tap.pad   = t_pad;
    for (int n = 0; n < `CONV_LANES; n++) begin
      tap.code[n] = w_rdata[2*n +: 2];
    end
  end

endmodule

// File: verilog/mac_unit.sv
`include "conv_params.svh"

module mac_unit
  import conv_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  wload_t load_w,
  input  wcode_t w_code,
  input  tap_t   tap,
  input  pixel_t pixel,
  input  quant_t quant,
  output pixel_t result
);

  wcode_t             codes [`CONV_MAX_TAPS];
  logic [3:0]         ptr;
  logic [3:0]         rd_idx;
  wcode_t             code;
  pixel_t             weight;
  logic signed [15:0] prod;
  acc_t               prod_q;
  acc_t               acc;
  acc_t               acc_nx;
  acc_t               shifted;
  pixel_t             sat;
  logic               v_q, first_q, last_q;

  // kernel codes in tap order
  always_ff @(posedge clk) begin
    if (load_w.valid) begin
      codes[load_w.idx] <= w_code;
    end
  end

  assign rd_idx = tap.first ? 4'd0 : ptr;
  assign code   = codes[rd_idx];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ptr <= '0;
    end else if (load_w.valid) begin
      ptr <= '0;
    end else if (tap.valid) begin
      ptr <= tap.last ? 4'd0 : rd_idx + 4'd1;
    end
  end

  // codebook
  always_comb begin
    case (code)
      2'd0:    weight = '0;
      2'd1:    weight = quant.pos_w;
      2'd2:    weight = quant.neg_w1;
      default: weight = quant.neg_w2;
    endcase
  end

  // padded taps contribute nothing
  assign prod = tap.pad ? 16'sd0 : pixel * weight;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      v_q     <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      v_q     <= tap.valid;
      first_q <= tap.valid && tap.first;
      last_q  <= tap.valid && tap.last;
    end
  end

  always_ff @(posedge clk) begin
    prod_q <= acc_t'(prod);
  end

  assign acc_nx  = (first_q ? 20'sd0 : acc) + prod_q;
  assign shifted = acc_nx >>> quant.shift;

  always_comb begin
    if (shifted > 127) begin
      sat = 8'sd127;
    end else if (shifted < -128) begin
      sat = -8'sd128;
    end else begin
      sat = shifted[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (v_q) begin
      acc <= acc_nx;
    end
    if (last_q) begin
      result <= sat;
    end
  end

endmodule

// File: verilog/conv_accel.sv
`include "conv_params.svh"

module conv_accel
  import conv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  host_req_t   host,
  output logic [31:0] host_rdata,
  output logic        finish
);

  addr_t  p_addr, w_addr, in_addr, out_addr;
  logic   in_re, out_we;
  wload_t load_w;
  quant_t quant;
  tap_t   tap;

  pixel_t [`CONV_LANES-1:0]  result;
  logic [`CONV_WORD_W-1:0]   out_wdata;
  logic [`CONV_WORD_W-1:0]   m_wdata;
  logic [`CONV_WORD_W-1:0]   m_rdata [4];
  logic [3:0]                c_en, c_we, m_en, m_we;
  addr_t                     c_addr [4];
  addr_t                     m_addr [4];
  logic                      started;
  logic                      host_mode;
  mem_sel_t                  rd_sel;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      started <= 1'b0;
      rd_sel  <= '0;
    end else begin
      if (start) started <= 1'b1;
      if (host.en && !host.we) rd_sel <= host.sel;
    end
  end

  // host owns the memories until the first start and after finish
  assign host_mode = finish || !started;

  assign c_en      = {out_we, in_re, 1'b1, 1'b1};
  assign c_we      = {out_we, 3'b000};
  assign c_addr[0] = p_addr;
  assign c_addr[1] = w_addr;
  assign c_addr[2] = in_addr;
  assign c_addr[3] = out_addr;

  always_comb begin
    logic hit;
    for (int i = 0; i < 4; i++) begin
      hit       = host.en && host.sel == mem_sel_t'(i);
      m_en[i]   = host_mode ? hit : c_en[i];
      m_we[i]   = host_mode ? hit && host.we : c_we[i];
      m_addr[i] = host_mode ? host.addr : c_addr[i];
    end
    m_wdata = host_mode ? host.wdata : out_wdata;
  end

  assign host_rdata = m_rdata[rd_sel];
  assign out_wdata  = result;

  conv_ram #(.DEPTH(`CONV_P_DEPTH), .WIDTH(`CONV_WORD_W)) p_ram (
    .clk(clk), .en(m_en[0]), .we(m_we[0]), .addr(m_addr[0]),
    .wdata(m_wdata), .rdata(m_rdata[0])
  );

  conv_ram #(.DEPTH(`CONV_W_DEPTH), .WIDTH(`CONV_WORD_W)) w_ram (
    .clk(clk), .en(m_en[1]), .we(m_we[1]), .addr(m_addr[1]),
    .wdata(m_wdata), .rdata(m_rdata[1])
  );

  conv_ram #(.DEPTH(`CONV_IMG_DEPTH), .WIDTH(`CONV_WORD_W)) in_ram (
    .clk(clk), .en(m_en[2]), .we(m_we[2]), .addr(m_addr[2]),
    .wdata(m_wdata), .rdata(m_rdata[2])
  );

  conv_ram #(.DEPTH(`CONV_OUT_DEPTH), .WIDTH(`CONV_WORD_W)) out_ram (
    .clk(clk), .en(m_en[3]), .we(m_we[3]), .addr(m_addr[3]),
    .wdata(m_wdata), .rdata(m_rdata[3])
  );

  conv_ctrl u_ctrl (
    .clk(clk), .rst(rst), .start(start),
    .p_rdata(m_rdata[0]), .w_rdata(m_rdata[1]),
    .finish(finish), .p_addr(p_addr), .w_addr(w_addr),
    .in_addr(in_addr), .in_re(in_re), .out_addr(out_addr), .out_we(out_we),
    .load_w(load_w), .quant(quant), .tap(tap)
  );

  // lane n takes code bits 2n+1:2n and writes output byte n
  for (genvar n = 0; n < `CONV_LANES; n++) begin : g_mac
    mac_unit u_mac (
      .clk(clk), .rst(rst), .load_w(load_w), .w_code(m_rdata[1][2*n +: 2]),
      .tap(tap), .pixel(m_rdata[2][7:0]), .quant(quant), .result(result[n])
    );
  end

endmodule

// File: dv/clk_gen.sv
module clk_gen (
  output logic clk,
  output logic rst
);

  // period of 10
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // reset held for 16 cycles, released on a falling edge
  initial begin
    rst = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

// File: dv/conv_chk.sv
module conv_chk
  import conv_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input ctrl_state_t state,
  input logic        finish,
  input logic        out_we,
  input tap_t        tap,
  input logic        in_re,
  input addr_t       in_addr,
  input logic [15:0] row_col,
  input wload_t      load_w
);

  int fail_cnt = 0;

  // nothing issued once the run is over
  quiet_when_done: assert property (@(posedge clk) disable iff (!rst)
    finish |-> !out_we && !tap.valid)
    else begin
      fail_cnt++;
      $error("out_we or tap valid high while finish is high");
    end

  image_read_in_range: assert property (@(posedge clk) disable iff (!rst)
    in_re |-> in_addr < row_col * row_col)
    else begin
      fail_cnt++;
      $error("image read at %0d outside a %0d pixel image", in_addr, row_col * row_col);
    end

  no_weight_load_in_conv: assert property (@(posedge clk) disable iff (!rst)
    state == S_CONV |-> !load_w.valid)
    else begin
      fail_cnt++;
      $error("weight load while convolving");
    end

endmodule

// File: dv/conv_tb.sv
module conv_tb
  import conv_pkg::*;
();

  localparam mem_sel_t SEL_PARAM  = 2'd0;
  localparam mem_sel_t SEL_WEIGHT = 2'd1;
  localparam mem_sel_t SEL_IMAGE  = 2'd2;
  localparam mem_sel_t SEL_OUT    = 2'd3;

  logic        clk;
  logic        rst;
  logic        start;
  host_req_t   host;
  logic [31:0] host_rdata;
  logic        finish;

  // headers, weights, pixels and expected words of all cases in file order
  logic [31:0] stim_q [$];
  int cycle_limit  = 0;
  int cycles       = 0;
  int checks       = 0;
  int mismatches   = 0;
  int other_errors = 0;

  clk_gen clk_gen_inst (.clk(clk), .rst(rst));

  conv_accel conv_accel_inst (
    .clk(clk), .rst(rst), .start(start), .host(host),
    .host_rdata(host_rdata), .finish(finish)
  );

  bind conv_ctrl conv_chk conv_chk_inst (
    .clk(clk), .rst(rst), .state(state), .finish(finish), .out_we(out_we),
    .tap(tap), .in_re(in_re), .in_addr(in_addr), .row_col(row_col), .load_w(load_w)
  );

  // skips comment lines starting with #
  task automatic next_value(input int fd, output logic [31:0] val, output bit got);
    string tok;
    int ch;
    got = 1'b0;
    val = '0;
    while (!got) begin
      if ($fscanf(fd, "%s", tok) != 1) return;
      if (tok[0] == "#") begin
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else if ($sscanf(tok, "%h", val) == 1) begin
        got = 1'b1;
      end
    end
  endtask

  task automatic load_stimulus(output int n_cases);
    int fd;
    logic [31:0] hdr [5];
    logic [31:0] w;
    bit got;
    bit whole;
    int rc, kk, grps, n_body;
    n_cases = 0;
    fd = $fopen("dv/conv_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/conv_stimulus.txt");
      other_errors++;
      return;
    end
    cycle_limit = 1000;
    forever begin
      next_value(fd, hdr[0], got);
      if (!got) break;
      whole = 1'b1;
      for (int i = 1; i < 5; i++) begin
        next_value(fd, hdr[i], got);
        whole &= got;
      end
      rc     = int'(hdr[0]);
      kk     = int'(hdr[2]);
      grps   = (int'(hdr[1]) + 3) / 4;
      // weights, pixels, then one expected word per pixel and group
      n_body = grps * kk * kk + rc * rc * (1 + grps);
      for (int i = 0; i < 5; i++) begin
        stim_q.push_back(hdr[i]);
      end
      for (int i = 0; i < n_body && whole; i++) begin
        next_value(fd, w, got);
        whole &= got;
        stim_q.push_back(w);
      end
      if (!whole) begin
        $display("stimulus file ends inside case %0d", n_cases + 1);
        other_errors++;
        break;
      end
      cycle_limit += 4 * (grps * (rc * rc * kk * kk + kk * kk + 10) + 20);
      n_cases++;
    end
    $fclose(fd);
  endtask

  task automatic write_mem(input mem_sel_t sel, input int addr, input logic [31:0] data);
    host.en    = 1'b1;
    host.we    = 1'b1;
    host.sel   = sel;
    host.addr  = addr_t'(addr);
    host.wdata = data;
    @(negedge clk);
    host = '0;
  endtask

  task automatic read_mem(input mem_sel_t sel, input int addr, output logic [31:0] data);
    host.en    = 1'b1;
    host.we    = 1'b0;
    host.sel   = sel;
    host.addr  = addr_t'(addr);
    host.wdata = '0;
    @(negedge clk);
    data = host_rdata;
    host = '0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_case();
    logic [31:0] hdr [5];
    logic [31:0] exp_word;
    logic [31:0] got_word;
    int rc, kk, grps;
    for (int i = 0; i < 5; i++) begin
      hdr[i] = stim_q.pop_front();
      write_mem(SEL_PARAM, i, hdr[i]);
    end
    rc   = int'(hdr[0]);
    kk   = int'(hdr[2]);
    grps = (int'(hdr[1]) + 3) / 4;
    for (int i = 0; i < grps * kk * kk; i++) begin
      write_mem(SEL_WEIGHT, i, stim_q.pop_front());
    end
    for (int i = 0; i < rc * rc; i++) begin
      write_mem(SEL_IMAGE, i, stim_q.pop_front());
    end
    pulse_start();
    while (!finish) begin
      @(negedge clk);
    end
    // output address is pixel times groups plus group
    for (int i = 0; i < rc * rc * grps; i++) begin
      exp_word = stim_q.pop_front();
      read_mem(SEL_OUT, i, got_word);
      checks++;
      if (got_word !== exp_word) begin
        mismatches++;
        $display("Mismatch at %0t: host_rdata at output address %0d, expected %h, actual %h",
                 $time, i, exp_word, got_word);
      end
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: test cases not done after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int n_cases;
    int gap;
    host  = '0;
    start = 1'b0;
    void'($urandom(32'h9bba));
    load_stimulus(n_cases);
    if (n_cases == 0) begin
      $display("no complete test case in the stimulus file");
      other_errors++;
    end
    wait (rst === 1'b1);
    @(negedge clk);
    for (int c = 0; c < n_cases; c++) begin
      gap = $urandom_range(5, 0);
      repeat (gap) @(negedge clk);
      run_case();
    end
    $display("checks %0d, mismatches %0d, assertion failures %0d, other errors %0d",
             checks, mismatches, conv_accel_inst.u_ctrl.conv_chk_inst.fail_cnt,
             other_errors);
    if (mismatches == 0 && other_errors == 0 &&
        conv_accel_inst.u_ctrl.conv_chk_inst.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: dv/conv_stimulus.txt
# per case, all hex: row_col out_ch k shift quant_word, then weight words,
# then pixel words, then expected output words in output address order
# case 1: 1x1 kernel over all four codebook codes, shift 2
4 4 1 2 03FEFB00
E4
00 01 FF 04 FC 07 0A F6
32 CE 64 9C 7F 80 21 B3
00000000 FEFF0000 0100FF00 FBFE0300 0502FD00 F7FC0500 F3FB0700 0C05F800
C1E72500 3E19DA00 83CE4B00 7D32B500 80C05F00 7F40A000 D6EF1800 6026C600
# case 2: 3x3 kernel on a 6x6 image with zero padding
6 4 3 0 01FFFD00
21 01 01 01 05 01 01 01 C1
00 01 02 03 04 05
02 03 04 05 06 07
04 05 06 07 08 09
06 07 08 09 0A 0B
08 09 0A 0B 0C 0D
0A 0B 0C 0D 0E 0F
F7000006 F400010C F1000212 EE000318 EB00041E 00000516
F100020F EE00031B EBFF0424 E8FE052D E5FD0636 00FC0727
EB00041B E8FE052D E5FD0636 E2FC073F DFFB0848 00FA0933
E5000627 E2FC073F DFFB0848 DCFA0951 D9F90A5A 00F80B3F
DF000833 DCFA0951 D9F90A5A D6F80B63 D3F70C6C 00F60D4B
00000A26 00F80B3C 00F70C42 00F60D48 00F50E4E 00F40F36
# case 3: two groups of four channels, saturation at shift 0
3 8 1 0 02FFFD00
39 93
64 9C 05 80 7F 3C C4 00 2A
00809C7F 9C7F0080 007F6480 6480007F 00F1FB0A FB0A00F1
007F7F80 7F80007F 0080817F 817F0080 0080C478 C4780080
007F3C88 3C88007F 00000000 00000000 0082D654 D6540082

// File: tb.f
+incdir+verilog
verilog/conv_pkg.sv
verilog/conv_ram.sv
verilog/conv_ctrl.sv
verilog/mac_unit.sv
verilog/conv_accel.sv
dv/clk_gen.sv
dv/conv_chk.sv
dv/conv_tb.sv

// File: Bender.yml
package:
  name: conv_accel

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/conv_pkg.sv
      - verilog/conv_ram.sv
      - verilog/conv_ctrl.sv
      - verilog/mac_unit.sv
      - verilog/conv_accel.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/clk_gen.sv
      - dv/conv_chk.sv
      - dv/conv_tb.sv
